//--- logic/tinker_pkg.sv
// tinker shared widths, opcodes, reset constants and pipeline record types
package tinker_pkg;

    // core widths
    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int REG_BITS = 5;
    localparam int LIT_BITS = 12;

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [REG_BITS-1:0] reg_idx_t;

    // reset values
    localparam word_t RESET_PC  = 64'h2000;
    localparam word_t STACK_TOP = 64'h80000;

    // 5-bit major opcode, instruction bits 31..27
    typedef enum logic [4:0] {
        OP_AND    = 5'b00000,
        OP_OR     = 5'b00001,
        OP_XOR    = 5'b00010,
        OP_NOT    = 5'b00011,
        OP_SHFTR  = 5'b00100,
        OP_SHFTRI = 5'b00101,
        OP_SHFTL  = 5'b00110,
        OP_SHFTLI = 5'b00111,
        OP_JUMP   = 5'b01000,
        OP_BRR    = 5'b01010,
        OP_BRNZ   = 5'b01011,
        OP_BRGT   = 5'b01110,
        OP_HALT   = 5'b01111,
        OP_LOAD   = 5'b10000,
        OP_MOV    = 5'b10001,
        OP_MOV_L  = 5'b10010,
        OP_STORE  = 5'b10011,
        OP_ADD    = 5'b11000,
        OP_ADDI   = 5'b11001,
        OP_SUB    = 5'b11010,
        OP_SUBI   = 5'b11011
    } opcode_e;

    // instruction fields after decode
    typedef struct packed {
        opcode_e              opcode;
        reg_idx_t             rd;
        reg_idx_t             rs;
        reg_idx_t             rt;
        logic [LIT_BITS-1:0]  lit;
        // clear when operand b is the literal
        logic                 uses_rt;
    } decoded_t;

    // execute stage side effects
    typedef struct packed {
        logic  reg_write;
        logic  mem_read;
        logic  mem_write;
        logic  take_branch;
        word_t target;
    } ex_ctl_t;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

endpackage

//--- logic/instr_decoder.sv
// instruction decoder, splits a tinker word into fields and flags rt usage
`timescale 1ns/1ps

module instr_decoder import tinker_pkg::*; (
    input  logic [ILEN-1:0] instruction,
    output decoded_t        fields
);

    always_comb begin
        // fixed field positions, same in every format
        fields.opcode = opcode_e'(instruction[31:27]);
        fields.rd     = instruction[26:22];
        fields.rs     = instruction[21:17];
        fields.rt     = instruction[16:12];
        fields.lit    = instruction[11:0];

        // literal forms take operand b from L
        case (fields.opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
            OP_MOV_L, OP_BRR, OP_STORE, OP_LOAD: begin
                fields.uses_rt = 1'b0;
            end
            default: begin
                fields.uses_rt = 1'b1;
            end
        endcase
    end

endmodule

//--- logic/register_file.sv
// register file, 32 x 64 with write-through bypass and a debug read port
`timescale 1ns/1ps

module register_file import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t rd_idx,
    input  reg_idx_t dbg_idx,
    output word_t    rs_value,
    output word_t    rt_value,
    output word_t    rd_value,
    output word_t    dbg_value
);

    word_t regs [32];

    // wb write seen by id read in the same cycle
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored);
        if (write_en && write_idx == idx) begin
            return write_data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            // r31 starts as the stack pointer
            regs[31] <= STACK_TOP;
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    assign rs_value  = read_port(rs_idx, regs[rs_idx]);
    assign rt_value  = read_port(rt_idx, regs[rt_idx]);
    assign rd_value  = read_port(rd_idx, regs[rd_idx]);
    // debug path, plain stored value
    assign dbg_value = regs[dbg_idx];

endmodule

//--- logic/alu.sv
// execute datapath, results, memory requests and branch resolution
`timescale 1ns/1ps

module alu import tinker_pkg::*; (
    input  word_t               pc,
    input  opcode_e             op,
    input  word_t               a,
    input  word_t               b,
    input  word_t               rd_value,
    input  logic [LIT_BITS-1:0] lit,
    output word_t               result,
    output ex_ctl_t             ctl
);

    always_comb begin
        result          = '0;
        ctl             = '0;
        // most opcodes write rd
        ctl.reg_write   = 1'b1;

        case (op)
            OP_ADD:    result = a + b;
            OP_SUB:    result = a - b;
            // immediate arithmetic updates rd in place
            OP_ADDI:   result = rd_value + b;
            OP_SUBI:   result = rd_value - b;
            OP_AND:    result = a & b;
            OP_OR:     result = a | b;
            OP_XOR:    result = a ^ b;
            OP_NOT:    result = ~a;
            OP_SHFTR,
            OP_SHFTRI: result = a >> b;
            OP_SHFTL,
            OP_SHFTLI: result = a << b;
            OP_MOV:    result = a;
            // upper 52 bits survive
            OP_MOV_L:  result = {rd_value[XLEN-1:LIT_BITS], lit};
            OP_LOAD: begin
                // effective address, memory data swapped in at wb
                result       = a + b;
                ctl.mem_read = 1'b1;
            end
            OP_STORE: begin
                // address from rd, data from rs
                result        = rd_value + b;
                ctl.reg_write = 1'b0;
                ctl.mem_write = 1'b1;
            end
            OP_JUMP: begin
                ctl.reg_write   = 1'b0;
                ctl.take_branch = 1'b1;
                ctl.target      = rd_value;
            end
            OP_BRR: begin
                // b holds sign-extended L
                ctl.reg_write   = 1'b0;
                ctl.take_branch = 1'b1;
                ctl.target      = pc + b;
            end
            OP_BRNZ: begin
                ctl.reg_write   = 1'b0;
                ctl.take_branch = (a != '0);
                ctl.target      = rd_value;
            end
            OP_BRGT: begin
                ctl.reg_write   = 1'b0;
                ctl.take_branch = ($signed(a) > $signed(b));
                ctl.target      = rd_value;
            end
            default: begin
                // halt and unused codes
                ctl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/memory.sv
// unified byte memory, fetch port, 64-bit data port and program load port
`timescale 1ns/1ps

module memory import tinker_pkg::*; #(
    parameter int MEM_ADDR_BITS = 19
) (
    input  logic            clk,
    input  word_t           fetch_addr,
    input  word_t           data_addr,
    input  logic            data_write,
    input  word_t           write_data,
    input  logic            load_en,
    input  logic [31:0]     load_addr,
    input  logic [31:0]     load_data,
    output logic [ILEN-1:0] instruction,
    output word_t           read_data
);

    typedef logic [MEM_ADDR_BITS-1:0] addr_t;

    logic [7:0] mem [1 << MEM_ADDR_BITS];

    // byte address, wraps at the memory size
    function automatic addr_t byte_addr(input word_t base, input int offset);
        return addr_t'(base + word_t'(offset));
    endfunction

    // little-endian combinational reads
    always_comb begin
        for (int i = 0; i < ILEN / 8; i++) begin
            instruction[8*i +: 8] = mem[byte_addr(fetch_addr, i)];
        end
        for (int i = 0; i < XLEN / 8; i++) begin
            read_data[8*i +: 8] = mem[byte_addr(data_addr, i)];
        end
    end

    // store wins over a program load
    always_ff @(posedge clk) begin
        if (data_write) begin
            for (int i = 0; i < XLEN / 8; i++) begin
                mem[byte_addr(data_addr, i)] <= write_data[8*i +: 8];
            end
        end else if (load_en) begin
            for (int i = 0; i < 4; i++) begin
                mem[byte_addr(word_t'(load_addr), i)] <= load_data[8*i +: 8];
            end
        end
    end

endmodule

//--- logic/hazard_unit.sv
// hazard unit, operand forwarding selects and load-use stall detect
`timescale 1ns/1ps

module hazard_unit import tinker_pkg::*; (
    input  reg_idx_t idex_rs,
    input  reg_idx_t idex_rt,
    input  reg_idx_t idex_rd,
    input  logic     idex_uses_rt,
    input  logic     idex_is_load,
    input  reg_idx_t exmem_rd,
    input  logic     exmem_write,
    input  reg_idx_t memwb_rd,
    input  logic     memwb_write,
    input  decoded_t ifid_fields,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output fwd_sel_e fwd_rd,
    output logic     stall
);

    logic reads_rs;
    logic reads_rd;

    // newest producer first
    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (exmem_write && exmem_rd == src) begin
            return FWD_EXMEM;
        end
        if (memwb_write && memwb_rd == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a  = pick(idex_rs);
        fwd_rd = pick(idex_rd);
        fwd_b  = idex_uses_rt ? pick(idex_rt) : FWD_REG;
    end

    // which id-stage sources are really read
    always_comb begin
        reads_rs = 1'b1;
        reads_rd = 1'b0;
        case (ifid_fields.opcode)
            OP_ADDI, OP_SUBI, OP_MOV_L: begin
                reads_rs = 1'b0;
                reads_rd = 1'b1;
            end
            OP_JUMP: begin
                reads_rs = 1'b0;
                reads_rd = 1'b1;
            end
            OP_STORE, OP_BRNZ, OP_BRGT: begin
                reads_rd = 1'b1;
            end
            OP_BRR, OP_HALT: begin
                reads_rs = 1'b0;
            end
            default: begin
                reads_rd = 1'b0;
            end
        endcase
    end

    // load data only exists after mem, one bubble covers it
    assign stall = idex_is_load &&
                   ((reads_rs && ifid_fields.rs == idex_rd) ||
                    (reads_rd && ifid_fields.rd == idex_rd) ||
                    (ifid_fields.uses_rt && ifid_fields.rt == idex_rd));

endmodule

//--- logic/tinker_core.sv
// tinker core top, five-stage pipeline with forwarding, load-use stall and branch flush
`timescale 1ns/1ps

module tinker_core import tinker_pkg::*; #(
    parameter int MEM_ADDR_BITS = 19
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  reg_idx_t    dbg_reg_sel,
    output word_t       dbg_reg_value,
    output logic        hlt
);

    // fetch
    word_t           pc;
    logic            fetch_stop;
    logic [ILEN-1:0] fetch_instr;
    // if/id and decode
    logic            ifid_valid;
    word_t           ifid_pc;
    logic [ILEN-1:0] ifid_instr;
    decoded_t        id_fields;
    word_t           id_rs_value;
    word_t           id_rt_value;
    word_t           id_rd_value;
    logic            halt_in_id;
    // id/ex
    logic            idex_valid;
    word_t           idex_pc;
    decoded_t        idex_fields;
    word_t           idex_rs_value;
    word_t           idex_rt_value;
    word_t           idex_rd_value;
    // execute
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    fwd_sel_e        fwd_rd;
    word_t           op_a;
    word_t           op_b;
    word_t           op_rd;
    word_t           alu_result;
    ex_ctl_t         alu_ctl;
    logic            stall;
    logic            flush;
    logic            idex_live;
    // ex/mem
    ex_ctl_t         exmem_ctl;
    reg_idx_t        exmem_rd;
    word_t           exmem_result;
    word_t           exmem_store_data;
    logic            exmem_halt;
    word_t           mem_read_data;
    // mem/wb
    logic            memwb_reg_write;
    logic            memwb_mem_read;
    logic            memwb_halt;
    reg_idx_t        memwb_rd;
    word_t           memwb_result;
    word_t           memwb_read_data;
    word_t           wb_data;

    memory #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_memory (
        .clk        (clk),
        .fetch_addr (pc),
        .data_addr  (exmem_result),
        .data_write (exmem_ctl.mem_write),
        .write_data (exmem_store_data),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .instruction(fetch_instr),
        .read_data  (mem_read_data)
    );

    instr_decoder u_decoder (
        .instruction(ifid_instr),
        .fields     (id_fields)
    );

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .write_en  (memwb_reg_write),
        .write_idx (memwb_rd),
        .write_data(wb_data),
        .rs_idx    (id_fields.rs),
        .rt_idx    (id_fields.rt),
        .rd_idx    (id_fields.rd),
        .dbg_idx   (dbg_reg_sel),
        .rs_value  (id_rs_value),
        .rt_value  (id_rt_value),
        .rd_value  (id_rd_value),
        .dbg_value (dbg_reg_value)
    );

    hazard_unit u_hazard (
        .idex_rs     (idex_fields.rs),
        .idex_rt     (idex_fields.rt),
        .idex_rd     (idex_fields.rd),
        .idex_uses_rt(idex_fields.uses_rt),
        .idex_is_load(idex_valid && idex_fields.opcode == OP_LOAD),
        .exmem_rd    (exmem_rd),
        .exmem_write (exmem_ctl.reg_write),
        .memwb_rd    (memwb_rd),
        .memwb_write (memwb_reg_write),
        .ifid_fields (id_fields),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fwd_rd      (fwd_rd),
        .stall       (stall)
    );

    // taken branch acts one stage late, from ex/mem
    assign flush      = exmem_ctl.take_branch;
    assign halt_in_id = ifid_valid && id_fields.opcode == OP_HALT;
    // instruction in ex that survives to ex/mem
    assign idex_live  = idex_valid && !flush;
    assign wb_data    = memwb_mem_read ? memwb_read_data : memwb_result;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_value,
                                      input word_t exmem_value, input word_t memwb_value);
        case (sel)
            FWD_EXMEM: return exmem_value;
            FWD_MEMWB: return memwb_value;
            default:   return reg_value;
        endcase
    endfunction

    always_comb begin
        op_a  = fwd_mux(fwd_a, idex_rs_value, exmem_result, wb_data);
        op_rd = fwd_mux(fwd_rd, idex_rd_value, exmem_result, wb_data);
        // literal forms get sign-extended L
        op_b  = idex_fields.uses_rt ? fwd_mux(fwd_b, idex_rt_value, exmem_result, wb_data)
                                    : {{(XLEN-LIT_BITS){idex_fields.lit[LIT_BITS-1]}},
                                       idex_fields.lit};
    end

    alu u_alu (
        .pc      (idex_pc),
        .op      (idex_fields.opcode),
        .a       (op_a),
        .b       (op_b),
        .rd_value(op_rd),
        .lit     (idex_fields.lit),
        .result  (alu_result),
        .ctl     (alu_ctl)
    );

    // pc, if/id valid and halt fetch stop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= RESET_PC;
            fetch_stop <= 1'b0;
            ifid_valid <= 1'b0;
        end else if (flush) begin
            pc         <= exmem_ctl.target;
            fetch_stop <= 1'b0;
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            if (fetch_stop || halt_in_id) begin
                // fetch frozen behind halt
                fetch_stop <= 1'b1;
                ifid_valid <= 1'b0;
            end else begin
                pc         <= pc + 64'd4;
                ifid_valid <= 1'b1;
            end
        end
    end

    // if/id payload, held on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc    <= pc;
            ifid_instr <= fetch_instr;
        end
    end

    // control flags for id/ex, ex/mem, mem/wb and halt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex_valid      <= 1'b0;
            exmem_ctl       <= '0;
            exmem_halt      <= 1'b0;
            memwb_reg_write <= 1'b0;
            memwb_mem_read  <= 1'b0;
            memwb_halt      <= 1'b0;
            hlt             <= 1'b0;
        end else begin
            // bubble on stall or flush
            idex_valid      <= ifid_valid && !stall && !flush;
            exmem_ctl       <= idex_live ? alu_ctl : '0;
            exmem_halt      <= idex_live && idex_fields.opcode == OP_HALT;
            memwb_reg_write <= exmem_ctl.reg_write;
            memwb_mem_read  <= exmem_ctl.mem_read;
            memwb_halt      <= exmem_halt;
            // sticky until reset
            if (memwb_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    // datapath payload
    always_ff @(posedge clk) begin
        idex_pc          <= ifid_pc;
        idex_fields      <= id_fields;
        idex_rs_value    <= id_rs_value;
        idex_rt_value    <= id_rt_value;
        idex_rd_value    <= id_rd_value;
        exmem_rd         <= idex_fields.rd;
        exmem_result     <= alu_result;
        // store data comes from rs
        exmem_store_data <= op_a;
        memwb_rd         <= exmem_rd;
        memwb_result     <= exmem_result;
        memwb_read_data  <= mem_read_data;
    end

endmodule

//--- bench/clock_gen.sv
// testbench clock and reset source, 20 ns clock with power-on reset
`timescale 1ns/1ps

module clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    input  logic hold,
    output logic clk,
    output logic reset
);

    logic por;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        por = 1'b0;
    end

    // tests may hold reset again to reload a program
    assign reset = por | hold;

endmodule

//--- bench/tb_tinker.sv
// testbench for the tinker core, directed programs checked against a reference model
`timescale 1ns/1ps

module tb_tinker import tinker_pkg::*; ();

    localparam int    MEM_ADDR_BITS = 19;
    localparam word_t MEM_MASK      = (64'd1 << MEM_ADDR_BITS) - 64'd1;

    logic        clk;
    logic        reset;
    logic        hold;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    reg_idx_t    dbg_reg_sel;
    word_t       dbg_reg_value;
    logic        hlt;

    // program image, byte offset from RESET_PC to word
    logic [ILEN-1:0] prog [int unsigned];
    int unsigned     prog_end;
    // reference state
    word_t           ref_regs [32];
    logic [7:0]      ref_mem [word_t];
    logic [31:0]     lfsr_state;

    clock_gen clocks (
        .hold (hold),
        .clk  (clk),
        .reset(reset)
    );

    tinker_core #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) dut (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .dbg_reg_sel  (dbg_reg_sel),
        .dbg_reg_value(dbg_reg_value),
        .hlt          (hlt)
    );

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [LIT_BITS-1:0] rand_lit();
        word_t v;
        v = rand_bits(LIT_BITS);
        return v[LIT_BITS-1:0];
    endfunction

    function automatic logic [ILEN-1:0] encode(input opcode_e op, input reg_idx_t rd,
                                               input reg_idx_t rs, input reg_idx_t rt,
                                               input logic [LIT_BITS-1:0] lit);
        return {op, rd, rs, rt, lit};
    endfunction

    function automatic word_t sext(input logic [LIT_BITS-1:0] lit);
        return {{(XLEN-LIT_BITS){lit[LIT_BITS-1]}}, lit};
    endfunction

    // byte address wraps at the memory size
    function automatic word_t mem_index(input word_t addr, input int i);
        return (addr + word_t'(i)) & MEM_MASK;
    endfunction

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s, got 0x%h, expected 0x%h",
                     $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    // effect of one executed instruction on the model
    task automatic model_exec(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs,
                              input reg_idx_t rt, input logic [LIT_BITS-1:0] lit);
        word_t addr;
        word_t data;
        data = '0;
        case (op)
            OP_ADD:    ref_regs[rd] = ref_regs[rs] + ref_regs[rt];
            OP_SUB:    ref_regs[rd] = ref_regs[rs] - ref_regs[rt];
            OP_ADDI:   ref_regs[rd] = ref_regs[rd] + sext(lit);
            OP_SUBI:   ref_regs[rd] = ref_regs[rd] - sext(lit);
            OP_AND:    ref_regs[rd] = ref_regs[rs] & ref_regs[rt];
            OP_OR:     ref_regs[rd] = ref_regs[rs] | ref_regs[rt];
            OP_XOR:    ref_regs[rd] = ref_regs[rs] ^ ref_regs[rt];
            OP_NOT:    ref_regs[rd] = ~ref_regs[rs];
            OP_SHFTR:  ref_regs[rd] = ref_regs[rs] >> ref_regs[rt];
            OP_SHFTRI: ref_regs[rd] = ref_regs[rs] >> lit;
            OP_SHFTL:  ref_regs[rd] = ref_regs[rs] << ref_regs[rt];
            OP_SHFTLI: ref_regs[rd] = ref_regs[rs] << lit;
            OP_MOV:    ref_regs[rd] = ref_regs[rs];
            // low 12 bits replaced
            OP_MOV_L:  ref_regs[rd] = {ref_regs[rd][XLEN-1:LIT_BITS], lit};
            OP_STORE: begin
                addr = ref_regs[rd] + sext(lit);
                for (int i = 0; i < 8; i++) begin
                    ref_mem[mem_index(addr, i)] = ref_regs[rs][8*i +: 8];
                end
            end
            OP_LOAD: begin
                // little endian, lowest byte first
                addr = ref_regs[rs] + sext(lit);
                for (int i = 0; i < 8; i++) begin
                    data[8*i +: 8] = ref_mem[mem_index(addr, i)];
                end
                ref_regs[rd] = data;
            end
            default: begin
                // branches and halt leave registers alone
            end
        endcase
    endtask

    // instruction on the executed path
    task automatic emit(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs,
                        input reg_idx_t rt, input logic [LIT_BITS-1:0] lit);
        prog[prog_end] = encode(op, rd, rs, rt, lit);
        prog_end += 4;
        model_exec(op, rd, rs, rt, lit);
    endtask

    // instruction that must be squashed, not modeled
    task automatic emit_dead(input opcode_e op, input reg_idx_t rd,
                             input logic [LIT_BITS-1:0] lit);
        prog[prog_end] = encode(op, rd, 5'd0, 5'd0, lit);
        prog_end += 4;
    endtask

    task automatic clear_model();
        prog.delete();
        prog_end = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_regs[31] = STACK_TOP;
    endtask

    // random 64-bit value built from literal chunks
    task automatic load_random(input reg_idx_t r);
        emit(OP_MOV_L, r, r, 5'd0, rand_lit());
        repeat (5) begin
            emit(OP_SHFTLI, r, r, 5'd0, 12'd12);
            emit(OP_MOV_L, r, r, 5'd0, rand_lit());
        end
    endtask

    // reset, load program, release, wait for halt
    task automatic run_program();
        int cycles;
        @(negedge clk);
        hold = 1'b1;
        foreach (prog[off]) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = RESET_PC[31:0] + off;
            load_data = prog[off];
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (16) @(negedge clk);
        hold = 1'b0;
        @(negedge clk);
        check_value("hlt right after reset", {63'd0, hlt}, 64'd0);
        cycles = 0;
        while (!hlt) begin
            if (cycles == 2000) begin
                $display("timeout, hlt did not rise within 2000 cycles");
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic read_reg(input reg_idx_t idx, output word_t value);
        @(negedge clk);
        dbg_reg_sel = idx;
        #2;
        value = dbg_reg_value;
    endtask

    task automatic check_all_regs();
        word_t value;
        for (int i = 0; i < 32; i++) begin
            read_reg(reg_idx_t'(i), value);
            check_value($sformatf("r%0d", i), value, ref_regs[i]);
        end
    endtask

    // lone halt, reset register values, hlt sticky
    task automatic reset_and_halt();
        clear_model();
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
        check_all_regs();
        repeat (20) begin
            @(negedge clk);
            check_value("hlt held after halt", {63'd0, hlt}, 64'd1);
        end
    endtask

    // each op consumes the last one or two results
    task automatic arith_chain();
        word_t amount;
        clear_model();
        load_random(5'd1);
        load_random(5'd2);
        emit(OP_ADD, 5'd3, 5'd1, 5'd2, 12'd0);
        emit(OP_SUB, 5'd4, 5'd3, 5'd1, 12'd0);
        emit(OP_XOR, 5'd5, 5'd4, 5'd3, 12'd0);
        emit(OP_AND, 5'd6, 5'd5, 5'd4, 12'd0);
        emit(OP_OR, 5'd7, 5'd6, 5'd5, 12'd0);
        // shift amount below 64
        amount = rand_bits(6);
        emit(OP_MOV_L, 5'd8, 5'd8, 5'd0, amount[LIT_BITS-1:0]);
        emit(OP_SHFTR, 5'd9, 5'd7, 5'd8, 12'd0);
        emit(OP_SHFTL, 5'd10, 5'd9, 5'd8, 12'd0);
        emit(OP_SUB, 5'd11, 5'd10, 5'd7, 12'd0);
        emit(OP_ADD, 5'd11, 5'd11, 5'd11, 12'd0);
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
        check_all_regs();
    endtask

    task automatic immediates_and_moves();
        clear_model();
        emit(OP_MOV_L, 5'd1, 5'd1, 5'd0, rand_lit());
        emit(OP_SHFTLI, 5'd1, 5'd1, 5'd0, 12'd20);
        // upper bits must survive
        emit(OP_MOV_L, 5'd1, 5'd1, 5'd0, rand_lit());
        // negative literals, -5 and -300
        emit(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'hffb);
        emit(OP_SUBI, 5'd1, 5'd0, 5'd0, 12'hed4);
        emit(OP_MOV, 5'd2, 5'd1, 5'd0, 12'd0);
        emit(OP_NOT, 5'd3, 5'd2, 5'd0, 12'd0);
        emit(OP_SHFTRI, 5'd4, 5'd3, 5'd0, 12'd7);
        emit(OP_SHFTLI, 5'd5, 5'd4, 5'd0, 12'd3);
        emit(OP_MOV_L, 5'd5, 5'd5, 5'd0, 12'h5a5);
        emit(OP_SUBI, 5'd6, 5'd0, 5'd0, 12'd1);
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
        check_all_regs();
    endtask

    // loads right before their consumers force the stall
    task automatic store_load_roundtrip();
        clear_model();
        emit(OP_MOV_L, 5'd10, 5'd10, 5'd0, 12'h400);
        emit(OP_SHFTLI, 5'd10, 5'd10, 5'd0, 12'd4);
        load_random(5'd1);
        load_random(5'd2);
        emit(OP_STORE, 5'd10, 5'd1, 5'd0, 12'd0);
        emit(OP_STORE, 5'd10, 5'd2, 5'd0, 12'd8);
        // straddles both stores, checks byte order
        emit(OP_LOAD, 5'd3, 5'd10, 5'd0, 12'd4);
        emit(OP_ADD, 5'd4, 5'd3, 5'd3, 12'd0);
        emit(OP_LOAD, 5'd5, 5'd10, 5'd0, 12'd0);
        emit(OP_ADDI, 5'd5, 5'd0, 5'd0, 12'd1);
        emit(OP_LOAD, 5'd6, 5'd10, 5'd0, 12'd8);
        emit(OP_STORE, 5'd10, 5'd6, 5'd0, 12'd16);
        emit(OP_LOAD, 5'd7, 5'd10, 5'd0, 12'd16);
        emit(OP_SUB, 5'd8, 5'd7, 5'd1, 12'd0);
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
        check_all_regs();
    endtask

    // r20 marker, r21 counts fall-through paths
    task automatic branch_flush();
        word_t value;
        clear_model();
        emit(OP_MOV_L, 5'd1, 5'd1, 5'd0, 12'd5);
        emit(OP_ADDI, 5'd3, 5'd0, 5'd0, 12'hffd);
        emit(OP_MOV_L, 5'd4, 5'd4, 5'd0, 12'd2);
        emit(OP_MOV_L, 5'd20, 5'd20, 5'd0, 12'h111);
        // r10 holds RESET_PC
        emit(OP_MOV_L, 5'd10, 5'd10, 5'd0, 12'h002);
        emit(OP_SHFTLI, 5'd10, 5'd10, 5'd0, 12'd12);
        emit(OP_MOV, 5'd11, 5'd10, 5'd0, 12'd0);
        emit(OP_MOV_L, 5'd11, 5'd11, 5'd0, 12'h100);
        // brnz on zero falls through, on r1 goes to block b
        emit(OP_BRNZ, 5'd11, 5'd2, 5'd0, 12'd0);
        emit(OP_ADDI, 5'd21, 5'd0, 5'd0, 12'd1);
        emit(OP_BRNZ, 5'd11, 5'd1, 5'd0, 12'd0);
        emit_dead(OP_ADDI, 5'd20, 12'd1);
        emit_dead(OP_ADDI, 5'd20, 12'd2);
        // block b, signed compare both ways
        prog_end = 32'h100;
        emit(OP_MOV, 5'd12, 5'd10, 5'd0, 12'd0);
        emit(OP_MOV_L, 5'd12, 5'd12, 5'd0, 12'h200);
        emit(OP_BRGT, 5'd12, 5'd3, 5'd4, 12'd0);
        emit(OP_ADDI, 5'd21, 5'd0, 5'd0, 12'd2);
        emit(OP_BRGT, 5'd12, 5'd4, 5'd3, 12'd0);
        emit_dead(OP_ADDI, 5'd20, 12'd4);
        emit_dead(OP_ADDI, 5'd20, 12'd8);
        // block c, relative hop forward
        prog_end = 32'h200;
        emit(OP_BRR, 5'd0, 5'd0, 5'd0, 12'h040);
        emit_dead(OP_ADDI, 5'd20, 12'd16);
        emit_dead(OP_ADDI, 5'd20, 12'd32);
        prog_end = 32'h240;
        emit(OP_MOV, 5'd13, 5'd10, 5'd0, 12'd0);
        emit(OP_MOV_L, 5'd13, 5'd13, 5'd0, 12'h300);
        emit(OP_JUMP, 5'd13, 5'd0, 5'd0, 12'd0);
        emit_dead(OP_ADDI, 5'd20, 12'd64);
        emit_dead(OP_ADDI, 5'd20, 12'd128);
        // block d, absolute target
        prog_end = 32'h300;
        emit(OP_ADDI, 5'd21, 5'd0, 5'd0, 12'd4);
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        run_program();
        read_reg(5'd20, value);
        check_value("marker r20 after flushes", value, 64'h111);
        read_reg(5'd21, value);
        check_value("fall-through count r21", value, 64'd7);
        check_all_regs();
    endtask

    initial begin
        hold        = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        dbg_reg_sel = '0;
        lfsr_state  = 32'h8b51e109;
        prog_end    = 0;

        reset_and_halt();
        arith_chain();
        immediates_and_moves();
        store_load_roundtrip();
        branch_flush();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- src.f
logic/tinker_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/memory.sv
logic/hazard_unit.sv
logic/tinker_core.sv
bench/clock_gen.sv
bench/tb_tinker.sv

//--- Makefile
TOP := tb_tinker

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
